// ==== io_pkg.sv ====
/* I/O package
   port offsets, GCU operations and cabinet input bundle of the main-CPU I/O space */
package io_pkg;

    localparam int JOY_W      = 7;  // 4 directions, 3 buttons
    localparam int OBJ_SLOT_W = 3;

    // GCU register offsets, byte address bits 3:0
    localparam logic [3:0] GCU_OFS_WRITE_REG  = 4'h0;
    localparam logic [3:0] GCU_OFS_SELECT_REG = 4'h4;
    localparam logic [3:0] GCU_OFS_RAM_H      = 4'h8;
    localparam logic [3:0] GCU_OFS_RAM_L      = 4'hA;
    localparam logic [3:0] GCU_OFS_RAM_PTR    = 4'hC;

    // byte offsets inside the I/O window
    typedef enum logic [7:0] {
        port_inputs     = 8'h00,  // player 1 and 2
        port_system     = 8'h02,  // dip c, start, coin
        port_dip_ab     = 8'h04,
        port_vstatus    = 8'h06,
        port_latch3     = 8'h08,
        port_latch4     = 8'h0A,
        port_snd_latch  = 8'h20,
        port_snd_latch2 = 8'h22,
        port_text_dma   = 8'h80,
        port_pal_dma    = 8'h82,
        port_obj_bank   = 8'hC0,  // whole 0xC0-0xCF block
        port_other      = 8'hFF
    } io_port_e;

    typedef enum logic [2:0] {
        gcu_select_reg,
        gcu_write_reg,
        gcu_write_ram,
        gcu_set_ram_ptr,
        gcu_objectbank_wr
    } gcu_op_e;

    // all bits active low
    typedef struct packed {
        logic [JOY_W-1:0] joy1;
        logic [JOY_W-1:0] joy2;
        logic [1:0]       start;
        logic [1:0]       coin;
        logic             service;
        logic             test;
    } cabinet_in_t;

endpackage

// ==== bus_pkg.sv ====
/* main bus package
   memory map and the request, response and decoded request types */
package bus_pkg;
    import io_pkg::*;

    localparam int ADDR_W = 23;  // word address, byte address bits 23:1
    localparam int RAM_AW = 14;
    localparam int DATA_W = 16;
    localparam int GCU_AW = 3;   // word bits inside the GCU window
    localparam int IO_AW  = 7;   // word bits inside the I/O window

    // word bases, byte address shifted down by one
    localparam logic [ADDR_W-1:0] VRAM_BASE = ADDR_W'(24'h20_0000 >> 1);  // to 0x207FFF
    localparam logic [ADDR_W-1:0] WRAM_BASE = ADDR_W'(24'h20_8000 >> 1);  // to 0x20FFFF
    localparam logic [ADDR_W-1:0] GCU_BASE  = ADDR_W'(24'h40_0000 >> 1);  // to 0x40000D
    localparam logic [ADDR_W-1:0] IO_BASE   = ADDR_W'(24'h50_0000 >> 1);  // to 0x5000FF

    typedef enum logic [2:0] {
        region_none,
        region_vram,
        region_wram,
        region_gcu,
        region_io
    } region_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
        logic [1:0]        be;  // upper, lower
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        region_e           region;
    } bus_rsp_t;

    // request after address decode
    typedef struct packed {
        bus_req_t req;
        region_e  region;
        io_port_e port;
    } dec_req_t;

endpackage

// ==== main_bus_decode.sv ====
/* main bus decoder
   accepts requests, maps them to a region and I/O port, holds off behind GCU work */
module main_bus_decode
    import bus_pkg::*;
    import io_pkg::*;
(
    input  logic     CLK96,
    input  logic     RESET96,
    input  logic     req_valid,
    input  bus_req_t req,
    output logic     req_ready,
    input  logic     gcu_busy,
    output logic     stage1_valid,
    output dec_req_t stage1
);

    logic     [7:0] io_ofs;
    dec_req_t       dec;
    logic           s1_gcu_wr;

    assign io_ofs = {req.addr[IO_AW-1:0], 1'b0};  // byte offset in the I/O window

    always_comb begin
        dec.req    = req;
        dec.region = region_none;
        if (req.addr[ADDR_W-1:RAM_AW] == VRAM_BASE[ADDR_W-1:RAM_AW]) begin
            dec.region = region_vram;
        end else if (req.addr[ADDR_W-1:RAM_AW] == WRAM_BASE[ADDR_W-1:RAM_AW]) begin
            dec.region = region_wram;
        end else if (req.addr[ADDR_W-1:GCU_AW] == GCU_BASE[ADDR_W-1:GCU_AW]) begin
            dec.region = region_gcu;
        end else if (req.addr[ADDR_W-1:IO_AW] == IO_BASE[ADDR_W-1:IO_AW]) begin
            dec.region = region_io;
        end

        case (io_ofs)
            8'h00:   dec.port = port_inputs;
            8'h02:   dec.port = port_system;
            8'h04:   dec.port = port_dip_ab;
            8'h06:   dec.port = port_vstatus;
            8'h08:   dec.port = port_latch3;
            8'h0A:   dec.port = port_latch4;
            8'h20:   dec.port = port_snd_latch;
            8'h22:   dec.port = port_snd_latch2;
            8'h80:   dec.port = port_text_dma;
            8'h82:   dec.port = port_pal_dma;
            default: dec.port = (io_ofs[7:4] == 4'hC) ? port_obj_bank : port_other;
        endcase
        if (dec.region != region_io) dec.port = port_other;
    end

    // object bank writes also become a GCU op
    assign s1_gcu_wr = stage1_valid && stage1.req.we &&
                       (stage1.region == region_gcu ||
                        (stage1.region == region_io && stage1.port == port_obj_bank));

    assign req_ready = !s1_gcu_wr && !gcu_busy;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= req_valid && req_ready;
        end
    end

    always_ff @(posedge CLK96) begin
        if (req_valid && req_ready) stage1 <= dec;
    end

    // master holds a stalled request unchanged
    a_req_stable: assert property (@(posedge CLK96) disable iff (RESET96)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

// ==== byte_lane_ram.sv ====
/* byte lane RAM
   16K words with upper and lower byte writes, registered read */
module byte_lane_ram
    import bus_pkg::*;
#(
    parameter region_e REGION = region_wram
) (
    input  logic              CLK96,
    input  logic              stage1_valid,
    input  dec_req_t          stage1,
    output logic [DATA_W-1:0] rd_data
);

    localparam int WORDS = 2 ** RAM_AW;

    logic [1:0][7:0]     mem [WORDS];
    logic [RAM_AW-1:0]   addr;
    logic                wr_en;

    assign addr  = stage1.req.addr[RAM_AW-1:0];
    assign wr_en = stage1_valid && stage1.req.we && stage1.region == REGION;

    always_ff @(posedge CLK96) begin
        if (wr_en && stage1.req.be[1]) begin
            mem[addr][1] <= stage1.req.wdata[15:8];  // upper lane
        end
        if (wr_en && stage1.req.be[0]) begin
            mem[addr][0] <= stage1.req.wdata[7:0];
        end
        rd_data <= mem[addr];  // old word on a write cycle
    end

endmodule

// ==== io_read_ports.sv ====
/* I/O read ports
   forms cabinet, DIP, video status and latch words and registers the bus response */
module io_read_ports
    import bus_pkg::*;
    import io_pkg::*;
(
    input  logic              CLK96,
    input  logic              RESET96,
    input  logic              stage1_valid,
    input  dec_req_t          stage1,
    input  logic [DATA_W-1:0] vram_data,
    input  logic [DATA_W-1:0] wram_data,
    input  cabinet_in_t       cabinet,
    input  logic [7:0]        dip_a,
    input  logic [7:0]        dip_b,
    input  logic [7:0]        dip_c,
    input  logic              flip,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              fblank,
    input  logic [8:0]        vpos,
    input  logic [7:0]        sound_latch3,
    input  logic [7:0]        sound_latch4,
    output logic              rsp_valid,
    output bus_rsp_t          rsp
);

    logic [DATA_W-1:0] port_word;
    logic [DATA_W-1:0] vstatus;
    logic [DATA_W-1:0] rd_mux;
    logic              s2_valid;
    logic              s2_we;
    region_e           s2_region;
    logic [DATA_W-1:0] s2_word;

    // board side is active high, directions swap pairwise on flip
    function automatic logic [7:0] player_byte(input logic [JOY_W-1:0] joy, input logic flp);
        logic [3:0] dirs;
        dirs = flp ? {~joy[1], ~joy[0], ~joy[3], ~joy[2]}
                   : {~joy[0], ~joy[1], ~joy[2], ~joy[3]};
        return {1'b0, ~joy[6:4], dirs};
    endfunction

    assign vstatus = {hsync, vsync, 5'b11111, fblank,
                      (vpos < 9'd256) ? vpos[7:0] : 8'hFF};

    always_comb begin
        case (stage1.port)
            port_inputs:  port_word = {player_byte(cabinet.joy2, flip),
                                       player_byte(cabinet.joy1, flip)};
            port_system:  port_word = {dip_c, 1'b0, ~cabinet.start[1], ~cabinet.start[0],
                                       ~cabinet.coin[1], ~cabinet.coin[0], ~cabinet.test,
                                       1'b0, ~cabinet.service};
            port_dip_ab:  port_word = {dip_b, dip_a};
            port_vstatus: port_word = vstatus;
            port_latch3:  port_word = {8'h00, sound_latch3};
            port_latch4:  port_word = {8'h00, sound_latch4};
            default:      port_word = '0;  // write-only or unused
        endcase
    end

    // stage 2 lines up with the RAM read data
    always_ff @(posedge CLK96) begin
        s2_we     <= stage1.req.we;
        s2_region <= stage1.region;
        s2_word   <= port_word;
    end

    always_comb begin
        case (s2_region)
            region_vram: rd_mux = vram_data;
            region_wram: rd_mux = wram_data;
            region_io:   rd_mux = s2_word;
            default:     rd_mux = '0;  // gcu and unmapped read as zero
        endcase
        if (s2_we) rd_mux = '0;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s2_valid  <= stage1_valid;
            rsp_valid <= s2_valid;
        end
    end

    always_ff @(posedge CLK96) begin
        rsp.rdata  <= rd_mux;
        rsp.region <= s2_region;
    end

endmodule

// ==== io_write_regs.sv ====
/* I/O write registers
   sound latches, DMA triggers and the held GCU operation with its handshake */
module io_write_regs
    import bus_pkg::*;
    import io_pkg::*;
(
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  stage1_valid,
    input  dec_req_t              stage1,
    input  logic                  tvram_busy,
    input  logic                  gcu_ack,
    output logic [7:0]            sound_latch,
    output logic [7:0]            sound_latch2,
    output logic                  text_dma_req,
    output logic                  pal_dma_req,
    output logic                  gcu_valid,
    output gcu_op_e               gcu_op,
    output logic [DATA_W-1:0]     gcu_data,
    output logic [OBJ_SLOT_W-1:0] gcu_slot,
    output logic                  gcu_busy
);

    logic       wr_io;
    logic       wr_gcu;
    logic       wr_obj;
    logic [3:0] gcu_ofs;
    logic       op_start;
    gcu_op_e    op_next;

    assign wr_io   = stage1_valid && stage1.req.we && stage1.region == region_io;
    assign wr_gcu  = stage1_valid && stage1.req.we && stage1.region == region_gcu;
    assign wr_obj  = wr_io && stage1.port == port_obj_bank;
    assign gcu_ofs = {stage1.req.addr[GCU_AW-1:0], 1'b0};

    always_comb begin
        op_start = 1'b0;
        op_next  = gcu_write_reg;
        if (wr_obj) begin
            op_start = 1'b1;
            op_next  = gcu_objectbank_wr;
        end else if (wr_gcu) begin
            op_start = 1'b1;
            case (gcu_ofs)
                GCU_OFS_WRITE_REG:            op_next = gcu_write_reg;
                GCU_OFS_SELECT_REG:           op_next = gcu_select_reg;
                GCU_OFS_RAM_H, GCU_OFS_RAM_L: op_next = gcu_write_ram;
                GCU_OFS_RAM_PTR:              op_next = gcu_set_ram_ptr;
                default:                      op_start = 1'b0;  // 2, 6, E ignored
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sound_latch  <= '0;
            sound_latch2 <= '0;
            text_dma_req <= 1'b0;
            pal_dma_req  <= 1'b0;
            gcu_valid    <= 1'b0;
        end else begin
            if (wr_io && stage1.port == port_snd_latch) sound_latch <= stage1.req.wdata[7:0];
            if (wr_io && stage1.port == port_snd_latch2) sound_latch2 <= stage1.req.wdata[7:0];

            // trigger wins over the clear
            if (wr_io && stage1.port == port_text_dma) begin
                text_dma_req <= 1'b1;
            end else if (!tvram_busy) begin
                text_dma_req <= 1'b0;
            end
            if (wr_io && stage1.port == port_pal_dma) begin
                pal_dma_req <= 1'b1;
            end else if (!tvram_busy) begin
                pal_dma_req <= 1'b0;
            end

            if (op_start) begin
                gcu_valid <= 1'b1;
            end else if (gcu_ack) begin
                gcu_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (op_start) begin
            gcu_op   <= op_next;
            gcu_data <= stage1.req.wdata;
        end
        if (wr_obj) gcu_slot <= stage1.req.addr[OBJ_SLOT_W-1:0];  // byte addr 3:1
    end

    assign gcu_busy = gcu_valid;  // decoder stalls on this

    // op and data held until the GCU takes them
    a_gcu_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        gcu_valid && !gcu_ack |=> gcu_valid && $stable(gcu_op) && $stable(gcu_data));

endmodule

// ==== main_bus_top.sv ====
/* main bus top
   decoder, VRAM and work RAM, I/O read ports and write registers of the CPU bus */
module main_bus_top
    import bus_pkg::*;
    import io_pkg::*;
(
    input  logic                  CLK96,
    input  logic                  RESET96,
    // master request and response
    input  logic                  req_valid,
    input  bus_req_t              req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output bus_rsp_t              rsp,
    // graphics controller
    output logic                  gcu_valid,
    output gcu_op_e               gcu_op,
    output logic [DATA_W-1:0]     gcu_data,
    output logic [OBJ_SLOT_W-1:0] gcu_slot,
    input  logic                  gcu_ack,
    // text and palette DMA
    output logic                  text_dma_req,
    output logic                  pal_dma_req,
    input  logic                  tvram_busy,
    // cabinet and video
    input  cabinet_in_t           cabinet,
    input  logic [7:0]            dip_a,
    input  logic [7:0]            dip_b,
    input  logic [7:0]            dip_c,
    input  logic                  flip,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  fblank,
    input  logic [8:0]            vpos,
    // sound CPU latches
    input  logic [7:0]            sound_latch3,
    input  logic [7:0]            sound_latch4,
    output logic [7:0]            sound_latch,
    output logic [7:0]            sound_latch2
);

    logic              stage1_valid;
    dec_req_t          stage1;
    logic [DATA_W-1:0] vram_data;
    logic [DATA_W-1:0] wram_data;
    logic              gcu_busy;

    main_bus_decode decode_i (
        .CLK96, .RESET96, .req_valid, .req, .req_ready, .gcu_busy, .stage1_valid, .stage1
    );

    byte_lane_ram #(.REGION(region_vram)) vram_i (
        .CLK96, .stage1_valid, .stage1, .rd_data(vram_data)
    );

    byte_lane_ram #(.REGION(region_wram)) wram_i (
        .CLK96, .stage1_valid, .stage1, .rd_data(wram_data)
    );

    io_read_ports rd_ports_i (
        .CLK96, .RESET96, .stage1_valid, .stage1, .vram_data, .wram_data,
        .cabinet, .dip_a, .dip_b, .dip_c, .flip, .hsync, .vsync, .fblank, .vpos,
        .sound_latch3, .sound_latch4, .rsp_valid, .rsp
    );

    io_write_regs wr_regs_i (
        .CLK96, .RESET96, .stage1_valid, .stage1, .tvram_busy, .gcu_ack,
        .sound_latch, .sound_latch2, .text_dma_req, .pal_dma_req,
        .gcu_valid, .gcu_op, .gcu_data, .gcu_slot, .gcu_busy
    );

endmodule

// ==== tb_main_bus_tasks.svh ====
/* main bus testbench tasks
   bus access, response collection, value check and the directed tests */
`ifndef TB_MAIN_BUS_TASKS_SVH
`define TB_MAIN_BUS_TASKS_SVH

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

// board memory map in byte addresses
function automatic region_e expected_region(input logic [23:0] byte_addr);
    if (byte_addr >= 24'h200000 && byte_addr <= 24'h207FFF) return region_vram;
    if (byte_addr >= 24'h208000 && byte_addr <= 24'h20FFFF) return region_wram;
    if (byte_addr >= 24'h400000 && byte_addr <= 24'h40000D) return region_gcu;
    if (byte_addr >= 24'h500000 && byte_addr <= 24'h5000FF) return region_io;
    return region_none;
endfunction

// starts just after a rising edge and returns one cycle after acceptance
task automatic send(input logic [23:0] byte_addr, input logic we, input logic [15:0] wdata,
                    input logic [1:0] be, output int acc_cyc);
    int waited;
    waited    = 0;
    req.addr  = byte_addr[23:1];
    req.we    = we;
    req.wdata = wdata;
    req.be    = be;
    req_valid = 1'b1;
    while (!req_ready && waited < STALL_LIMIT) begin
        @(posedge CLK96);
        #1;
        waited++;
    end
    if (!req_ready) begin
        errors++;
        $display("request to byte address 0x%h was never accepted", byte_addr);
    end
    @(posedge CLK96);
    #1;
    acc_cyc   = cyc;
    req_valid = 1'b0;
endtask

task automatic get_rsp(input int acc_cyc, output logic [15:0] rdata, output region_e region);
    int waited;
    waited = 0;
    while (rsp_q.size() == 0 && waited < RSP_LIMIT) begin
        @(posedge CLK96);
        #1;
        waited++;
    end
    if (rsp_q.size() == 0) begin
        errors++;
        $display("no response for the request accepted in cycle %0d", acc_cyc);
        rdata  = 'x;
        region = region_none;
    end else begin
        rdata  = rsp_q.pop_front();
        region = rsp_region_q.pop_front();
        check("rsp_valid latency", rsp_cyc_q.pop_front() - acc_cyc, 2);
    end
endtask

task automatic access(input logic [23:0] byte_addr, input logic we, input logic [15:0] wdata,
                      input logic [1:0] be, input logic [15:0] exp);
    int          acc_cyc;
    logic [15:0] rdata;
    region_e     region;
    send(byte_addr, we, wdata, be, acc_cyc);
    get_rsp(acc_cyc, rdata, region);
    check($sformatf("rsp.rdata at 0x%h", byte_addr), rdata, exp);
    check($sformatf("rsp.region at 0x%h", byte_addr), region, expected_region(byte_addr));
endtask

task automatic reset_state();
    check("req_ready", req_ready, 1);
    check("rsp_valid", rsp_valid, 0);
    check("gcu_valid", gcu_valid, 0);
    check("text_dma_req", text_dma_req, 0);
    check("pal_dma_req", pal_dma_req, 0);
    check("sound_latch", sound_latch, 0);
    check("sound_latch2", sound_latch2, 0);
endtask

// same offset in both RAMs, then single byte lanes
task automatic ram_byte_lanes();
    access(24'h200010, 1'b1, 16'h1234, 2'b11, 16'h0000);
    access(24'h208010, 1'b1, 16'hABCD, 2'b11, 16'h0000);
    access(24'h200010, 1'b0, 16'h0000, 2'b11, 16'h1234);
    access(24'h208010, 1'b0, 16'h0000, 2'b11, 16'hABCD);
    access(24'h200010, 1'b1, 16'h5699, 2'b10, 16'h0000);
    access(24'h208010, 1'b1, 16'h77EF, 2'b01, 16'h0000);
    access(24'h200010, 1'b0, 16'h0000, 2'b11, 16'h5634);
    access(24'h208010, 1'b0, 16'h0000, 2'b11, 16'hABEF);
endtask

task automatic back_to_back_reads();
    logic [23:0] addrs [5];
    logic [15:0] exps [5];
    int          acc [5];
    logic [15:0] rdata;
    region_e     region;
    // last two are an unmapped and a GCU read that both return zero
    addrs = '{24'h200010, 24'h208010, 24'h500004, 24'h300000, 24'h400004};
    exps  = '{16'h5634, 16'hABEF, 16'hC33C, 16'h0000, 16'h0000};
    for (int i = 0; i < 5; i++) begin
        send(addrs[i], 1'b0, 16'h0000, 2'b11, acc[i]);
        check("acceptance cycle", acc[i] - acc[0], i);
    end
    for (int i = 0; i < 5; i++) begin
        get_rsp(acc[i], rdata, region);
        check($sformatf("rsp.rdata at 0x%h", addrs[i]), rdata, exps[i]);
        check($sformatf("rsp.region at 0x%h", addrs[i]), region, expected_region(addrs[i]));
    end
endtask

task automatic player_inputs();
    cabinet.joy1 = 7'b0110101;
    cabinet.joy2 = 7'b1001110;
    flip = 1'b0;
    access(24'h500000, 1'b0, 16'h0000, 2'b11, 16'h3845);
    flip = 1'b1;  // pairs of directions swap
    access(24'h500000, 1'b0, 16'h0000, 2'b11, 16'h344A);
    flip = 1'b0;
endtask

task automatic status_words();
    dip_c           = 8'h5A;
    cabinet.start   = 2'b10;
    cabinet.coin    = 2'b01;
    cabinet.service = 1'b0;
    cabinet.test    = 1'b1;
    access(24'h500002, 1'b0, 16'h0000, 2'b11, 16'h5A31);
    access(24'h500004, 1'b0, 16'h0000, 2'b11, 16'hC33C);
    hsync  = 1'b1;
    vsync  = 1'b0;
    fblank = 1'b1;
    vpos   = 9'h0A5;
    access(24'h500006, 1'b0, 16'h0000, 2'b11, 16'hBFA5);
    hsync  = 1'b0;
    vsync  = 1'b1;
    fblank = 1'b0;
    vpos   = 9'h123;  // past line 255 reads as 0xFF
    access(24'h500006, 1'b0, 16'h0000, 2'b11, 16'h7EFF);
    sound_latch3 = 8'h9C;
    sound_latch4 = 8'h21;
    access(24'h500008, 1'b0, 16'h0000, 2'b11, 16'h009C);
    access(24'h50000A, 1'b0, 16'h0000, 2'b11, 16'h0021);
endtask

task automatic latches_and_dma();
    tvram_busy = 1'b1;
    access(24'h500020, 1'b1, 16'hBE77, 2'b11, 16'h0000);
    check("sound_latch", sound_latch, 8'h77);
    access(24'h500022, 1'b1, 16'h1234, 2'b11, 16'h0000);
    check("sound_latch2", sound_latch2, 8'h34);
    access(24'h500080, 1'b1, 16'h0001, 2'b11, 16'h0000);
    check("text_dma_req", text_dma_req, 1);
    access(24'h500082, 1'b1, 16'h0001, 2'b11, 16'h0000);
    check("pal_dma_req", pal_dma_req, 1);
    check("text_dma_req", text_dma_req, 1);
    tvram_busy = 1'b0;
    @(posedge CLK96);
    #1;
    check("text_dma_req", text_dma_req, 0);
    check("pal_dma_req", pal_dma_req, 0);
endtask

task automatic gcu_ops();
    logic [23:0] addrs [7];
    logic [15:0] wdata [7];
    gcu_op_e     ops [7];
    int          waited;
    addrs = '{24'h400000, 24'h400004, 24'h400008, 24'h40000A, 24'h40000C,
              24'h5000CA, 24'h5000C4};
    wdata = '{16'h1111, 16'h2222, 16'h3333, 16'h4444, 16'h5555, 16'h00A5, 16'h005A};
    ops   = '{gcu_write_reg, gcu_select_reg, gcu_write_ram, gcu_write_ram,
              gcu_set_ram_ptr, gcu_objectbank_wr, gcu_objectbank_wr};
    op_q.delete();
    data_q.delete();
    slot_q.delete();
    for (int i = 0; i < 7; i++) access(addrs[i], 1'b1, wdata[i], 2'b11, 16'h0000);
    waited = 0;
    while (gcu_valid && waited < STALL_LIMIT) begin
        @(posedge CLK96);
        #1;
        waited++;
    end
    check("gcu op count", op_q.size(), 7);
    for (int i = 0; i < 7 && i < op_q.size(); i++) begin
        check("gcu_op", op_q[i], ops[i]);
        check("gcu_data", data_q[i], wdata[i]);
    end
    if (op_q.size() == 7) begin
        check("gcu_slot", slot_q[5], 3'd5);
        check("gcu_slot", slot_q[6], 3'd2);
    end
endtask

`endif

// ==== tb_main_bus.sv ====
/* main bus testbench
   clock, reset, DUT, GCU responder, response monitor and run limit */
module tb_main_bus
    import bus_pkg::*;
    import io_pkg::*;
();

    localparam int RESET_CYCLES  = 5;
    localparam int STALL_LIMIT   = 8;   // GCU delay 0..3 plus ack and stage 1
    localparam int RSP_LIMIT     = 6;
    localparam int ACCESSES      = 40;  // bus accesses over all tests rounded up
    localparam int ACCESS_CYCLES = 12;  // worst stall plus response
    localparam int MAX_CYCLES    = RESET_CYCLES + ACCESSES * ACCESS_CYCLES + 20;

    logic                  CLK96;
    logic                  RESET96;
    logic                  req_valid;
    bus_req_t              req;
    logic                  req_ready;
    logic                  rsp_valid;
    bus_rsp_t              rsp;
    logic                  gcu_valid;
    gcu_op_e               gcu_op;
    logic [DATA_W-1:0]     gcu_data;
    logic [OBJ_SLOT_W-1:0] gcu_slot;
    logic                  gcu_ack;
    logic                  text_dma_req;
    logic                  pal_dma_req;
    logic                  tvram_busy;
    cabinet_in_t           cabinet;
    logic [7:0]            dip_a;
    logic [7:0]            dip_b;
    logic [7:0]            dip_c;
    logic                  flip;
    logic                  hsync;
    logic                  vsync;
    logic                  fblank;
    logic [8:0]            vpos;
    logic [7:0]            sound_latch3;
    logic [7:0]            sound_latch4;
    logic [7:0]            sound_latch;
    logic [7:0]            sound_latch2;

    int                    cyc = 0;
    int                    errors = 0;
    int                    checks = 0;
    logic [DATA_W-1:0]     rsp_q[$];
    region_e               rsp_region_q[$];
    int                    rsp_cyc_q[$];
    gcu_op_e               op_q[$];     // ops as seen by the GCU
    logic [DATA_W-1:0]     data_q[$];
    logic [OBJ_SLOT_W-1:0] slot_q[$];

    `include "tb_main_bus_tasks.svh"

    main_bus_top dut_i (
        .CLK96, .RESET96, .req_valid, .req, .req_ready, .rsp_valid, .rsp,
        .gcu_valid, .gcu_op, .gcu_data, .gcu_slot, .gcu_ack,
        .text_dma_req, .pal_dma_req, .tvram_busy,
        .cabinet, .dip_a, .dip_b, .dip_c, .flip, .hsync, .vsync, .fblank, .vpos,
        .sound_latch3, .sound_latch4, .sound_latch, .sound_latch2
    );

    initial CLK96 = 1'b0;
    always #2 CLK96 = ~CLK96;

    always @(posedge CLK96) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cyc);
            $display("Regression failed");
            $finish;
        end
    end

    // response capture and GCU stall check on the falling edge
    always @(negedge CLK96) begin
        if (rsp_valid) begin
            rsp_q.push_back(rsp.rdata);
            rsp_region_q.push_back(rsp.region);
            rsp_cyc_q.push_back(cyc);
        end
        if (gcu_valid && req_ready) begin
            errors++;
            $display("req_ready was high while a GCU op waited for its ack");
        end
    end

    // GCU model acks each op after 0 to 3 idle cycles
    initial begin
        int delay;
        gcu_ack = 1'b0;
        void'($urandom(1372));
        forever begin
            @(posedge CLK96);
            #1;
            if (gcu_valid) begin
                op_q.push_back(gcu_op);
                data_q.push_back(gcu_data);
                slot_q.push_back(gcu_slot);
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge CLK96);
                    #1;
                end
                gcu_ack = 1'b1;
                @(posedge CLK96);
                #1;
                gcu_ack = 1'b0;
            end
        end
    end

    initial begin
        RESET96      = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        tvram_busy   = 1'b0;
        cabinet      = '1;  // nothing pressed
        dip_a        = 8'h3C;
        dip_b        = 8'hC3;
        dip_c        = 8'h00;
        flip         = 1'b0;
        hsync        = 1'b0;
        vsync        = 1'b0;
        fblank       = 1'b0;
        vpos         = '0;
        sound_latch3 = 8'h00;
        sound_latch4 = 8'h00;
        repeat (RESET_CYCLES) @(posedge CLK96);
        #1;
        RESET96 = 1'b0;

        reset_state();
        ram_byte_lanes();
        back_to_back_reads();
        player_inputs();
        status_words();
        latches_and_dma();
        gcu_ops();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
io_pkg.sv
bus_pkg.sv
main_bus_decode.sv
byte_lane_ram.sv
io_read_ports.sv
io_write_regs.sv
main_bus_top.sv
tb_main_bus.sv

// ==== Bender.yml ====
package:
  name: main_bus

sources:
  - files:
      - io_pkg.sv
      - bus_pkg.sv
      - main_bus_decode.sv
      - byte_lane_ram.sv
      - io_read_ports.sv
      - io_write_regs.sv
      - main_bus_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_main_bus.sv
